//--- all.f
hdl/video_pkg.sv
hdl/sync_tracker.sv
hdl/pixel_decimator.sv
hdl/bram_writer.sv
hdl/hdmi_capture_top.sv
test/tb_hdmi_capture.sv

//--- Makefile
# Verilator build and run of the HDMI capture testbench

VERILATOR ?= verilator
TOP       ?= tb_hdmi_capture
LOG       ?= sim.log
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail is decided from the log
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_hdmi_capture.sv
`timescale 1ns/100ps

module tb_hdmi_capture;

	// reduced test geometry, default shift kept
	localparam int ACTIVE_W = 64;
	localparam int SHIFT = video_pkg::DEF_SCALE_SHIFT;
	localparam int GROUP = 1 << SHIFT;
	localparam int LINES = 16;
	localparam int WRITES_PER_FRAME = (LINES / GROUP) * (ACTIVE_W / GROUP);
	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;

	logic                  pclk;
	logic                  rst_n;
	video_pkg::pixel_t     vid_data;
	logic                  vid_de;
	logic                  vid_hsync;
	logic                  vid_vsync;
	logic                  ena;
	video_pkg::bram_addr_t bram_addr;
	video_pkg::channel_t   rgb_r;
	video_pkg::channel_t   rgb_g;
	video_pkg::channel_t   rgb_b;
	logic                  start_frame;

	// pixel source state
	logic [15:0] lfsr_state;
	// current line as it goes out
	video_pkg::pixel_t line_buf [ACTIVE_W];
	// expected writes, {address, r, g, b}
	logic [39:0] exp_q [$];
	logic [39:0] exp_word;
	// next address the model hands out
	logic [15:0] exp_addr;
	int write_count;

	hdmi_capture_top #(
		.ACTIVE_WIDTH (ACTIVE_W)
	) hdmi_capture_top_inst (
		.pclk_i        (pclk),
		.rst_n_i       (rst_n),
		.vid_data_i    (vid_data),
		.vid_de_i      (vid_de),
		.vid_hsync_i   (vid_hsync),
		.vid_vsync_i   (vid_vsync),
		.ena_o         (ena),
		.bram_addr_o   (bram_addr),
		.rgb_r_o       (rgb_r),
		.rgb_g_o       (rgb_g),
		.rgb_b_o       (rgb_b),
		.start_frame_o (start_frame)
	);

	// 8 ns pixel clock
	initial pclk = 1'b0;
	always #4 pclk = ~pclk;

	task automatic halt_run();
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, what, got, expected);
			halt_run();
		end
	endtask

	// galois form, x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic [15:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ 16'hB400;
		end
		return n;
	endfunction

	// one lfsr step per pixel bit
	task automatic draw_pixel(output video_pkg::pixel_t p);
		p = '0;
		for (int i = 0; i < video_pkg::PIXEL_W; i++) begin
			p = {p[video_pkg::PIXEL_W-2:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	// truncated box mean of every group in line_buf
	function automatic void model_line();
		int sum_r;
		int sum_g;
		int sum_b;
		for (int g = 0; g < ACTIVE_W / GROUP; g++) begin
			sum_r = 0;
			sum_g = 0;
			sum_b = 0;
			for (int k = 0; k < GROUP; k++) begin
				sum_r += int'(line_buf[g*GROUP+k][23:16]);
				sum_g += int'(line_buf[g*GROUP+k][15:8]);
				sum_b += int'(line_buf[g*GROUP+k][7:0]);
			end
			exp_q.push_back({exp_addr, 8'(sum_r / GROUP), 8'(sum_g / GROUP),
				8'(sum_b / GROUP)});
			exp_addr = exp_addr + 16'd1;
		end
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic drive(input logic de, input logic hs, input logic vs,
			input video_pkg::pixel_t d);
		@(posedge pclk);
		#1;
		vid_de    = de;
		vid_hsync = hs;
		vid_vsync = vs;
		vid_data  = d;
	endtask

	task automatic idle(input int n);
		repeat (n) drive(1'b0, 1'b0, 1'b0, '0);
	endtask

	// hsync, back porch, n_pix active pixels, front porch
	task automatic send_line(input bit model, input bit solid,
			input video_pkg::pixel_t colour, input int n_pix);
		video_pkg::pixel_t px;
		// whole line known before its writes come out
		for (int i = 0; i < ACTIVE_W; i++) begin
			if (solid) begin
				px = colour;
			end else begin
				draw_pixel(px);
			end
			line_buf[i] = px;
		end
		if (model) begin
			model_line();
		end
		repeat (4) drive(1'b0, 1'b1, 1'b0, '0);
		idle(4);
		for (int i = 0; i < n_pix; i++) begin
			drive(1'b1, 1'b0, 1'b0, line_buf[i]);
		end
		idle(4);
	endtask

	// only every GROUP-th line of a modelled frame gives writes
	task automatic send_lines(input bit model, input bit solid,
			input video_pkg::pixel_t colour, input int first, input int count);
		for (int l = first; l < first + count; l++) begin
			send_line(model && (l % GROUP == 0), solid, colour, ACTIVE_W);
		end
	endtask

	task automatic send_vsync();
		repeat (4) drive(1'b0, 1'b0, 1'b1, '0);
		idle(6);
		exp_addr = '0;
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0) begin
			if (cycles >= WAIT_LIMIT) begin
				$display("timeout: %0d expected BRAM writes still missing after %0d cycles",
					exp_q.size(), WAIT_LIMIT);
				halt_run();
			end else begin
				@(posedge pclk);
				cycles++;
			end
		end
	endtask

	// complete frame, then count its writes
	task automatic run_frame(input bit solid, input video_pkg::pixel_t colour);
		int base;
		base = write_count;
		send_vsync();
		send_lines(1'b1, solid, colour, 0, LINES);
		idle(8);
		wait_drain();
		check_value("writes in frame", 32'(write_count - base), 32'(WRITES_PER_FRAME));
	endtask

	// sample mid cycle, outputs settled
	always @(negedge pclk) begin
		if (!rst_n) begin
			if (ena || start_frame) begin
				$display("BRAM write strobes are high during reset at %0t ns", $time);
				halt_run();
			end
		end else if (ena) begin
			if (exp_q.size() == 0) begin
				$display("a BRAM write at %0t ns came with no write expected", $time);
				halt_run();
			end else begin
				exp_word = exp_q.pop_front();
				check_value("address", 32'(bram_addr), 32'(exp_word[39:24]));
				check_value("red", 32'(rgb_r), 32'(exp_word[23:16]));
				check_value("green", 32'(rgb_g), 32'(exp_word[15:8]));
				check_value("blue", 32'(rgb_b), 32'(exp_word[7:0]));
				// frame pulse exactly on address 0
				check_value("start_frame", 32'(start_frame),
					32'(exp_word[39:24] == 16'd0));
				write_count++;
			end
		end else if (start_frame) begin
			$display("start_frame_o raised without a write at %0t ns", $time);
			halt_run();
		end
	end

	initial begin
		int base;
		lfsr_state  = 16'd14736;
		rst_n       = 1'b0;
		vid_data    = '0;
		vid_de      = 1'b0;
		vid_hsync   = 1'b0;
		vid_vsync   = 1'b0;
		exp_addr    = '0;
		write_count = 0;
		repeat (10) @(posedge pclk);
		#1;
		rst_n = 1'b1;

		// quiet after reset
		idle(20);
		// video without a vsync in front writes nothing
		base = write_count;
		send_lines(1'b0, 1'b0, '0, 0, LINES);
		idle(8);
		check_value("writes before first vsync", 32'(write_count - base), 32'd0);

		// random content
		run_frame(1'b0, '0);
		run_frame(1'b0, '0);
		// solid colours, distinct bytes per channel
		run_frame(1'b1, 24'hC35A17);
		run_frame(1'b1, 24'h2B94E0);

		// reset part way into kept line 8
		send_vsync();
		send_lines(1'b1, 1'b0, '0, 0, 8);
		send_line(1'b1, 1'b0, '0, 30);
		@(posedge pclk);
		#1;
		rst_n = 1'b0;
		// groups cut off by reset never get written
		exp_q.delete();
		repeat (10) @(posedge pclk);
		#1;
		rst_n = 1'b1;
		// rest of the broken frame is ignored
		base = write_count;
		send_lines(1'b0, 1'b0, '0, 9, LINES - 9);
		idle(8);
		check_value("writes after reset before vsync", 32'(write_count - base), 32'd0);
		// next full frame restarts at address 0
		run_frame(1'b0, '0);
		idle(10);

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- hdl/hdmi_capture_top.sv
`timescale 1ns/100ps

module hdmi_capture_top #(
	parameter int ACTIVE_WIDTH = video_pkg::DEF_ACTIVE_WIDTH,
	parameter int SCALE_SHIFT  = video_pkg::DEF_SCALE_SHIFT
) (
	input  logic                  pclk_i,
	input  logic                  rst_n_i,
	input  video_pkg::pixel_t     vid_data_i,
	input  logic                  vid_de_i,
	input  logic                  vid_hsync_i,
	input  logic                  vid_vsync_i,
	output logic                  ena_o,
	output video_pkg::bram_addr_t bram_addr_o,
	output video_pkg::channel_t   rgb_r_o,
	output video_pkg::channel_t   rgb_g_o,
	output video_pkg::channel_t   rgb_b_o,
	output logic                  start_frame_o
);

	// tracker to decimator
	logic              pix_valid;
	video_pkg::pixel_t pix_data;
	video_pkg::coord_t pix_col;
	video_pkg::coord_t pix_line;
	logic              frame_start;

	// decimator to writer
	logic              avg_valid;
	video_pkg::pixel_t avg_data;
	logic              avg_first;

	sync_tracker sync_tracker_inst (
		.pclk_i        (pclk_i),
		.rst_n_i       (rst_n_i),
		.vid_data_i    (vid_data_i),
		.vid_de_i      (vid_de_i),
		.vid_hsync_i   (vid_hsync_i),
		.vid_vsync_i   (vid_vsync_i),
		.pix_valid_o   (pix_valid),
		.pix_data_o    (pix_data),
		.pix_col_o     (pix_col),
		.pix_line_o    (pix_line),
		.frame_start_o (frame_start)
	);

	pixel_decimator #(
		.SCALE_SHIFT (SCALE_SHIFT)
	) pixel_decimator_inst (
		.pclk_i        (pclk_i),
		.rst_n_i       (rst_n_i),
		.pix_valid_i   (pix_valid),
		.pix_data_i    (pix_data),
		.pix_col_i     (pix_col),
		.pix_line_i    (pix_line),
		.frame_start_i (frame_start),
		.avg_valid_o   (avg_valid),
		.avg_data_o    (avg_data),
		.avg_first_o   (avg_first)
	);

	bram_writer #(
		.ACTIVE_WIDTH (ACTIVE_WIDTH),
		.SCALE_SHIFT  (SCALE_SHIFT)
	) bram_writer_inst (
		.pclk_i        (pclk_i),
		.rst_n_i       (rst_n_i),
		.avg_valid_i   (avg_valid),
		.avg_data_i    (avg_data),
		.avg_first_i   (avg_first),
		.ena_o         (ena_o),
		.bram_addr_o   (bram_addr_o),
		.rgb_r_o       (rgb_r_o),
		.rgb_g_o       (rgb_g_o),
		.rgb_b_o       (rgb_b_o),
		.start_frame_o (start_frame_o)
	);

endmodule

//--- hdl/bram_writer.sv
`timescale 1ns/100ps

module bram_writer #(
	parameter int ACTIVE_WIDTH = video_pkg::DEF_ACTIVE_WIDTH,
	parameter int SCALE_SHIFT  = video_pkg::DEF_SCALE_SHIFT
) (
	input  logic                  pclk_i,
	input  logic                  rst_n_i,
	input  logic                  avg_valid_i,
	input  video_pkg::pixel_t     avg_data_i,
	input  logic                  avg_first_i,
	output logic                  ena_o,
	output video_pkg::bram_addr_t bram_addr_o,
	output video_pkg::channel_t   rgb_r_o,
	output video_pkg::channel_t   rgb_g_o,
	output video_pkg::channel_t   rgb_b_o,
	output logic                  start_frame_o
);

	// reduced width times the largest reduced line count
	localparam int ADDR_LIMIT =
		(ACTIVE_WIDTH >> SCALE_SHIFT) * (1 << (video_pkg::COORD_W - SCALE_SHIFT));

	// address the following write will use
	video_pkg::bram_addr_t addr_q;

	always_ff @(posedge pclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ena_o         <= 1'b0;
			start_frame_o <= 1'b0;
			bram_addr_o   <= '0;
			addr_q        <= '0;
		end else begin
			ena_o         <= avg_valid_i;
			// frame pulse only with a real write
			start_frame_o <= avg_valid_i & avg_first_i;

			if (avg_valid_i) begin
				if (avg_first_i) begin
					// new frame, back to the base of the buffer
					bram_addr_o <= '0;
					addr_q      <= video_pkg::bram_addr_t'(1);
				end else begin
					bram_addr_o <= addr_q;
					addr_q      <= addr_q + 1'b1;
				end
			end
		end
	end

	// channel split, red sits in the top byte
	always_ff @(posedge pclk_i) begin
		if (avg_valid_i) begin
			rgb_r_o <= avg_data_i[23:16];
			rgb_g_o <= avg_data_i[15:8];
			rgb_b_o <= avg_data_i[7:0];
		end
	end

	// writes stay inside the reduced frame area
	a_addr_in_range : assert property (
		@(posedge pclk_i) disable iff (!rst_n_i)
		ena_o |-> (int'(bram_addr_o) < ADDR_LIMIT)
	);

endmodule

//--- hdl/pixel_decimator.sv
`timescale 1ns/100ps

module pixel_decimator #(
	parameter int SCALE_SHIFT = video_pkg::DEF_SCALE_SHIFT
) (
	input  logic               pclk_i,
	input  logic               rst_n_i,
	input  logic               pix_valid_i,
	input  video_pkg::pixel_t  pix_data_i,
	input  video_pkg::coord_t  pix_col_i,
	input  video_pkg::coord_t  pix_line_i,
	input  logic               frame_start_i,
	output logic               avg_valid_o,
	output video_pkg::pixel_t  avg_data_o,
	output logic               avg_first_o
);

	// room for 2^SCALE_SHIFT channel bytes
	localparam int ACC_W = video_pkg::CHANNEL_W + SCALE_SHIFT;
	localparam int NUM_CH = video_pkg::PIXEL_W / video_pkg::CHANNEL_W;

	// per channel running sums with red at index 2
	logic [NUM_CH-1:0][ACC_W-1:0] acc_q;
	logic [NUM_CH-1:0][ACC_W-1:0] acc_next;
	video_pkg::pixel_t avg_next;

	logic line_kept;
	logic grp_start;
	logic grp_end;
	logic take;
	logic emit;

	// a frame has started since reset
	logic locked_q;
	// frame opened but no average out yet
	logic first_pend_q;

	// keep every 2^SCALE_SHIFT-th line
	assign line_kept = (pix_line_i[SCALE_SHIFT-1:0] == '0);
	// group boundaries from the low column bits
	assign grp_start = (pix_col_i[SCALE_SHIFT-1:0] == '0);
	assign grp_end   = &pix_col_i[SCALE_SHIFT-1:0];

	assign take = pix_valid_i & line_kept;
	// nothing goes out until the first frame start
	assign emit = take & grp_end & (locked_q | frame_start_i);

	always_comb begin
		for (int c = 0; c < NUM_CH; c++) begin
			// restart the sum on the first pixel of a group
			acc_next[c] = (grp_start ? '0 : acc_q[c])
				+ ACC_W'(pix_data_i[c*video_pkg::CHANNEL_W +: video_pkg::CHANNEL_W]);
			// truncated mean drops the low bits
			avg_next[c*video_pkg::CHANNEL_W +: video_pkg::CHANNEL_W] =
				acc_next[c][ACC_W-1:SCALE_SHIFT];
		end
	end

	always_ff @(posedge pclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			avg_valid_o  <= 1'b0;
			avg_first_o  <= 1'b0;
			locked_q     <= 1'b0;
			first_pend_q <= 1'b0;
		end else begin
			avg_valid_o <= emit;
			avg_first_o <= emit & (first_pend_q | frame_start_i);

			if (frame_start_i) begin
				locked_q <= 1'b1;
			end

			// first flag rides on the next average
			if (emit) begin
				first_pend_q <= 1'b0;
			end else if (frame_start_i) begin
				first_pend_q <= 1'b1;
			end
		end
	end

	// group sums and the averaged pixel
	always_ff @(posedge pclk_i) begin
		if (take) begin
			acc_q <= acc_next;
		end
		if (emit) begin
			avg_data_o <= avg_next;
		end
	end

	// the first pixel of an averaged group was also on a kept line
	a_no_avg_on_dropped_line : assert property (
		@(posedge pclk_i) disable iff (!rst_n_i)
		avg_valid_o |->
			$past(pix_valid_i && pix_line_i[SCALE_SHIFT-1:0] == '0, 1 << SCALE_SHIFT)
	);

endmodule

//--- hdl/sync_tracker.sv
`timescale 1ns/100ps

module sync_tracker (
	input  logic               pclk_i,
	input  logic               rst_n_i,
	input  video_pkg::pixel_t  vid_data_i,
	input  logic               vid_de_i,
	input  logic               vid_hsync_i,
	input  logic               vid_vsync_i,
	output logic               pix_valid_o,
	output video_pkg::pixel_t  pix_data_o,
	output video_pkg::coord_t  pix_col_o,
	output video_pkg::coord_t  pix_line_o,
	output logic               frame_start_o
);

	// previous input levels for edge detection
	logic de_q;
	logic vs_q;

	// column of the next pixel in the line
	video_pkg::coord_t col_q;
	// index the next line will get
	video_pkg::coord_t line_q;

	// set by vsync and cleared by the first active pixel
	logic armed_q;

	logic de_rise;
	logic vs_rise;

	assign de_rise = vid_de_i & ~de_q;
	assign vs_rise = vid_vsync_i & ~vs_q;

	// the registered de level is the pixel strobe
	assign pix_valid_o = de_q;

	always_ff @(posedge pclk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			de_q          <= 1'b0;
			vs_q          <= 1'b0;
			col_q         <= '0;
			line_q        <= '0;
			armed_q       <= 1'b0;
			pix_col_o     <= '0;
			pix_line_o    <= '0;
			frame_start_o <= 1'b0;
		end else begin
			de_q <= vid_de_i;
			vs_q <= vid_vsync_i;

			// first active pixel after a vsync edge opens the frame
			frame_start_o <= vid_de_i & armed_q;
			if (vs_rise) begin
				armed_q <= 1'b1;
			end else if (vid_de_i) begin
				armed_q <= 1'b0;
			end

			// column count restarts on each de edge
			if (vid_de_i) begin
				if (de_rise) begin
					pix_col_o <= '0;
					col_q     <= video_pkg::coord_t'(1);
				end else begin
					pix_col_o <= col_q;
					col_q     <= col_q + 1'b1;
				end
			end else if (vid_hsync_i) begin
				// nothing in flight during horizontal blanking
				col_q <= '0;
			end

			// line count steps once per de edge
			if (vs_rise) begin
				line_q <= '0;
			end else if (de_rise) begin
				pix_line_o <= line_q;
				line_q     <= line_q + 1'b1;
			end
		end
	end

	// pixel payload follows the input by one cycle
	always_ff @(posedge pclk_i) begin
		pix_data_o <= vid_data_i;
	end

endmodule

//--- hdl/video_pkg.sv
package video_pkg;

	// bit widths of the shared vectors
	localparam int PIXEL_W     = 24;
	localparam int CHANNEL_W   = 8;
	localparam int COORD_W     = 12;
	localparam int BRAM_ADDR_W = 16;

	// packed pixel, red high byte, green middle, blue low
	typedef logic [PIXEL_W-1:0] pixel_t;

	// one colour channel
	typedef logic [CHANNEL_W-1:0] channel_t;

	// column or line inside the active area
	typedef logic [COORD_W-1:0] coord_t;

	// word address into the frame BRAM
	typedef logic [BRAM_ADDR_W-1:0] bram_addr_t;

	// default active width, 720p source
	localparam int DEF_ACTIVE_WIDTH = 1280;

	// log2 of the reduction factor, 4x per axis
	localparam int DEF_SCALE_SHIFT = 2;

endpackage
